// ==== hw/jobPkg.sv ====
`default_nettype none

package jobPkg;

    // workers and jobs
    localparam int jobCount = 8;
    localparam int indexWidth = 3;

    // 8! assignments
    localparam int permCount = 40320;

    // permutation generator states
    localparam logic [1:0] stHold = 2'd0;
    localparam logic [1:0] stPivot = 2'd1;
    localparam logic [1:0] stSwap = 2'd2;
    localparam logic [1:0] stReverse = 2'd3;

endpackage

`default_nettype wire

// ==== hw/costPkg.sv ====
`default_nettype none

package costPkg;

    // one cost-memory entry
    localparam int costWidth = 7;

    // eight entries of at most 127 stay below 1024
    localparam int sumWidth = 10;

    // holds the full 40320 when every assignment ties
    localparam int countWidth = 16;

    localparam logic [sumWidth-1:0] sumMax = '1;

endpackage

`default_nettype wire

// ==== hw/permuteGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module permuteGen import jobPkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [indexWidth-1:0] worker,
    input  logic                  advance,
    output logic [indexWidth-1:0] job,
    output logic                  ready,
    output logic                  last
);

    logic [indexWidth-1:0] perm [jobCount];
    logic [indexWidth-1:0] nextPerm [jobCount];
    logic [indexWidth-1:0] pivotIdx;
    logic [indexWidth-1:0] swapIdx;
    logic [1:0]            state;

    assign job = perm[worker];
    assign ready = (state == stHold);

    // no ascent left means this is 7..0
    always_comb begin
        last = 1'b1;
        for (int k = 0; k < jobCount - 1; k++) begin
            if (perm[k] < perm[k + 1]) begin
                last = 1'b0;
            end
        end
    end

    // pivot takes the swap entry and the tail after the pivot is mirrored
    // with the old pivot value landing where the swap entry mirrors to
    always_comb begin
        int m;
        for (int k = 0; k < jobCount; k++) begin
            m = jobCount + int'(pivotIdx) - k;
            if (k < int'(pivotIdx)) begin
                nextPerm[k] = perm[k];
            end else if (k == int'(pivotIdx)) begin
                nextPerm[k] = perm[swapIdx];
            end else if (indexWidth'(m) == swapIdx) begin
                nextPerm[k] = perm[pivotIdx];
            end else begin
                nextPerm[k] = perm[indexWidth'(m)];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < jobCount; k++) begin
                perm[k] <= indexWidth'(k);
            end
            pivotIdx <= '0;
            swapIdx <= '0;
            state <= stHold;
        end else begin
            case (state)
                stHold: begin
                    if (advance) begin
                        pivotIdx <= indexWidth'(jobCount - 2);
                        state <= stPivot;
                    end
                end
                stPivot: begin
                    // first ascent seen from the right
                    if (perm[pivotIdx] < perm[pivotIdx + 1'b1]) begin
                        swapIdx <= indexWidth'(jobCount - 1);
                        state <= stSwap;
                    end else begin
                        pivotIdx <= pivotIdx - 1'b1;
                    end
                end
                stSwap: begin
                    // rightmost entry larger than the pivot
                    if (perm[swapIdx] > perm[pivotIdx]) begin
                        state <= stReverse;
                    end else begin
                        swapIdx <= swapIdx - 1'b1;
                    end
                end
                stReverse: begin
                    for (int k = 0; k < jobCount; k++) begin
                        perm[k] <= nextPerm[k];
                    end
                    state <= stHold;
                end
                default: begin
                    state <= stHold;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/costSummer.sv ====
`timescale 1ns/1ps
`default_nettype none

module costSummer import jobPkg::*, costPkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  ready,
    input  logic                  last,
    input  logic [indexWidth-1:0] job,
    input  logic [costWidth-1:0]  cost,
    output logic [indexWidth-1:0] worker,
    output logic                  advance,
    output logic                  costRead,
    output logic [indexWidth-1:0] costWorker,
    output logic [indexWidth-1:0] costJob,
    output logic [sumWidth-1:0]   sum,
    output logic                  sumValid,
    output logic                  finalSum
);

    logic [indexWidth-1:0] readIdx;
    logic                  busy;
    logic                  readDly;
    logic                  lastDly;

    assign worker = readIdx;
    assign costWorker = readIdx;
    assign costJob = job;

    always_ff @(posedge clk) begin
        if (rst) begin
            readIdx <= '0;
            busy <= 1'b0;
            costRead <= 1'b0;
            readDly <= 1'b0;
            lastDly <= 1'b0;
            sumValid <= 1'b0;
            advance <= 1'b0;
            finalSum <= 1'b0;
        end else begin
            // new permutation is stable
            if (!busy && ready) begin
                busy <= 1'b1;
                costRead <= 1'b1;
                readIdx <= '0;
            end

            if (costRead) begin
                readIdx <= readIdx + 1'b1;
                if (readIdx == indexWidth'(jobCount - 1)) begin
                    costRead <= 1'b0;
                end
            end

            // cost memory answers one cycle after the strobe
            readDly <= costRead;
            lastDly <= costRead && (readIdx == indexWidth'(jobCount - 1));

            sumValid <= lastDly;
            advance <= lastDly && !last;
            finalSum <= lastDly && last;

            // after the final sum the summer stays busy for good
            if (sumValid && !finalSum) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && ready) begin
            sum <= '0;
        end else if (readDly) begin
            sum <= sum + sumWidth'(cost);
        end
    end

endmodule

`default_nettype wire

// ==== hw/minTracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module minTracker import costPkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [sumWidth-1:0]   sum,
    input  logic                  sumValid,
    input  logic                  finalSum,
    output logic [sumWidth-1:0]   minCost,
    output logic [countWidth-1:0] matchCount,
    output logic                  done
);

    always_ff @(posedge clk) begin
        if (rst) begin
            minCost <= sumMax;
            matchCount <= '0;
            done <= 1'b0;
        end else if (sumValid) begin
            if (sum < minCost) begin
                // new best restarts the count
                minCost <= sum;
                matchCount <= countWidth'(1);
            end else if (sum == minCost) begin
                matchCount <= matchCount + 1'b1;
            end
            if (finalSum) begin
                done <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/jobAssign.sv ====
`timescale 1ns/1ps
`default_nettype none

module jobAssign import jobPkg::*, costPkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [costWidth-1:0]  cost,
    output logic                  costRead,
    output logic [indexWidth-1:0] costWorker,
    output logic [indexWidth-1:0] costJob,
    output logic [sumWidth-1:0]   minCost,
    output logic [countWidth-1:0] matchCount,
    output logic                  done
);

    logic [indexWidth-1:0] worker;
    logic [indexWidth-1:0] job;
    logic                  ready;
    logic                  last;
    logic                  advance;
    logic [sumWidth-1:0]   sum;
    logic                  sumValid;
    logic                  finalSum;

    permuteGen gen (
        .clk     (clk),
        .rst     (rst),
        .worker  (worker),
        .advance (advance),
        .job     (job),
        .ready   (ready),
        .last    (last)
    );

    costSummer summer (
        .clk        (clk),
        .rst        (rst),
        .ready      (ready),
        .last       (last),
        .job        (job),
        .cost       (cost),
        .worker     (worker),
        .advance    (advance),
        .costRead   (costRead),
        .costWorker (costWorker),
        .costJob    (costJob),
        .sum        (sum),
        .sumValid   (sumValid),
        .finalSum   (finalSum)
    );

    minTracker tracker (
        .clk        (clk),
        .rst        (rst),
        .sum        (sum),
        .sumValid   (sumValid),
        .finalSum   (finalSum),
        .minCost    (minCost),
        .matchCount (matchCount),
        .done       (done)
    );

endmodule

`default_nettype wire

// ==== verif/costMatrices.svh ====
`ifndef COST_MATRICES_SVH
`define COST_MATRICES_SVH

// each row gives name, matrix kind, kind parameter, expected minCost and matchCount
// uniform takes the parameter as every cost
// diagonal and anti-diagonal take it as the off-diagonal cost
// random takes it as the exclusive upper bound of each entry
// an expected value of -1 leaves both results to the brute-force model
task automatic loadTable();
    addRow("uniform13", kindUniform, 13, 104, 40320);
    addRow("uniform127", kindUniform, 127, 1016, 40320);
    addRow("diagonal", kindDiagonal, 100, 0, 1);
    addRow("antiDiagonal", kindAntiDiagonal, 100, 0, 1);
    addRow("randomWide", kindRandom, 128, -1, -1);
    addRow("randomNarrow", kindRandom, 3, -1, -1);
endtask

`endif

// ==== verif/jobAssignTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module jobAssignTb import jobPkg::*, costPkg::*; ();

    localparam int kindUniform = 0;
    localparam int kindDiagonal = 1;
    localparam int kindAntiDiagonal = 2;
    localparam int kindRandom = 3;
    localparam int resetCycles = 3;
    localparam int settleCycles = 20;
    localparam int cyclesPerPerm = 30;

    logic                  clk;
    logic                  rst;
    logic [costWidth-1:0]  cost;
    logic                  costRead;
    logic [indexWidth-1:0] costWorker;
    logic [indexWidth-1:0] costJob;
    logic [sumWidth-1:0]   minCost;
    logic [countWidth-1:0] matchCount;
    logic                  done;

    string nameQ[$];
    int    kindQ[$];
    int    paramQ[$];
    int    expMinQ[$];
    int    expCountQ[$];

    logic [costWidth-1:0]  costMem [jobCount][jobCount];
    string                 testName;
    int                    cycleCount = 0;
    int                    cycleLimit = 0;
    int                    readCount = 0;
    logic [jobCount-1:0]   jobsSeen;
    logic                  pendRead;
    logic [indexWidth-1:0] pendWorker;
    logic [indexWidth-1:0] pendJob;

    jobAssign uut (
        .clk        (clk),
        .rst        (rst),
        .cost       (cost),
        .costRead   (costRead),
        .costWorker (costWorker),
        .costJob    (costJob),
        .minCost    (minCost),
        .matchCount (matchCount),
        .done       (done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic addRow(input string name, input int kind, input int param,
                          input int expMin, input int expCount);
        nameQ.push_back(name);
        kindQ.push_back(kind);
        paramQ.push_back(param);
        expMinQ.push_back(expMin);
        expCountQ.push_back(expCount);
    endtask

    `include "costMatrices.svh"

    task automatic stopWithFailure();
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic fillMatrix(input int kind, input int param);
        for (int w = 0; w < jobCount; w++) begin
            for (int j = 0; j < jobCount; j++) begin
                case (kind)
                    kindUniform: costMem[w][j] = costWidth'(param);
                    kindDiagonal: costMem[w][j] = (w == j) ? costWidth'(0) : costWidth'(param);
                    kindAntiDiagonal: begin
                        costMem[w][j] = (j == jobCount - 1 - w) ? costWidth'(0)
                                                                : costWidth'(param);
                    end
                    default: costMem[w][j] = costWidth'($urandom % param);
                endcase
            end
        end
    endtask

    // every assignment n decoded by its factorial digits
    function automatic void bruteForce(output int bestSum, output int bestCount);
        int pool [jobCount];
        int rest;
        int radix;
        int pick;
        int total;
        bestSum = 1 << sumWidth;
        bestCount = 0;
        for (int n = 0; n < permCount; n++) begin
            for (int k = 0; k < jobCount; k++) begin
                pool[k] = k;
            end
            rest = n;
            radix = permCount;
            total = 0;
            for (int w = 0; w < jobCount; w++) begin
                radix = radix / (jobCount - w);
                pick = rest / radix;
                rest = rest % radix;
                total += int'(costMem[w][pool[pick]]);
                // drop the used job from the pool
                for (int k = pick; k < jobCount - 1 - w; k++) begin
                    pool[k] = pool[k + 1];
                end
            end
            if (total < bestSum) begin
                bestSum = total;
                bestCount = 1;
            end else if (total == bestSum) begin
                bestCount++;
            end
        end
    endfunction

    // cost memory with one cycle of latency and junk between reads
    always @(posedge clk) begin
        #1;
        cost = pendRead ? costMem[pendWorker][pendJob] : costWidth'(7'h55);
    end

    // read monitor
    always @(negedge clk) begin
        pendRead = costRead;
        pendWorker = costWorker;
        pendJob = costJob;
        if (rst) begin
            readCount = 0;
            jobsSeen = '0;
        end else if (costRead) begin
            assert (!done) else begin
                $display("cost read issued after done in %s", testName);
                stopWithFailure();
            end
            assert (costWorker == indexWidth'(readCount % jobCount)) else begin
                $display("mismatch %s worker: expected %0d, actual %0d",
                         testName, readCount % jobCount, costWorker);
                stopWithFailure();
            end
            assert (!jobsSeen[costJob]) else begin
                $display("job %0d read twice within one assignment in %s", costJob, testName);
                stopWithFailure();
            end
            jobsSeen[costJob] = 1'b1;
            readCount++;
            if (readCount % jobCount == 0) begin
                jobsSeen = '0;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("timeout after %0d cycles without finishing the table", cycleLimit);
            stopWithFailure();
        end
    end

    initial begin
        int expMin;
        int expCount;
        void'($urandom(71));
        rst = 1'b1;
        cost = '0;
        pendRead = 1'b0;
        pendWorker = '0;
        pendJob = '0;
        testName = "";
        loadTable();
        cycleLimit = nameQ.size() * (permCount * cyclesPerPerm + resetCycles + settleCycles);
        for (int t = 0; t < nameQ.size(); t++) begin
            testName = nameQ[t];
            fillMatrix(kindQ[t], paramQ[t]);
            if (expMinQ[t] < 0) begin
                bruteForce(expMin, expCount);
            end else begin
                expMin = expMinQ[t];
                expCount = expCountQ[t];
            end
            rst = 1'b1;
            repeat (resetCycles) nextCycle();
            rst = 1'b0;
            while (!done) begin
                nextCycle();
            end
            assert (int'(minCost) == expMin) else begin
                $display("mismatch %s minCost: expected %0d, actual %0d",
                         testName, expMin, minCost);
                stopWithFailure();
            end
            assert (int'(matchCount) == expCount) else begin
                $display("mismatch %s matchCount: expected %0d, actual %0d",
                         testName, expCount, matchCount);
                stopWithFailure();
            end
            // quiet window after done
            repeat (settleCycles) nextCycle();
            assert (readCount == jobCount * permCount) else begin
                $display("mismatch %s reads: expected %0d, actual %0d",
                         testName, jobCount * permCount, readCount);
                stopWithFailure();
            end
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== jobAssign.f ====
+incdir+verif
hw/jobPkg.sv
hw/costPkg.sv
hw/permuteGen.sv
hw/costSummer.sv
hw/minTracker.sv
hw/jobAssign.sv
verif/jobAssignTb.sv

// ==== Makefile ====
SIM = obj_dir/jobAssignSim

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f jobAssign.f --top-module jobAssign

sim:
	verilator --binary --timing -j 0 -f jobAssign.f --top-module jobAssignTb -o jobAssignSim
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
